/* source/line_pkg.sv */
package line_pkg;

	////////////////////
	// Line geometry
	////////////////////

	localparam int line_w = 640;
	localparam int word_pix = 4;
	localparam int line_words = line_w / word_pix;
	localparam int tile_pix = 8;

	////////////////////
	// Pixel and memory word
	////////////////////

	// Palette index as sent to the palette stage, color 0 is transparent
	typedef struct packed {
		logic [3:0] palette;
		logic [3:0] color;
	} pix_t;

	// One memory word, four pixels with their priorities and written flags
	typedef struct packed {
		pix_t [3:0] pix;
		logic [3:0][1:0] z;
		logic [3:0] written;
	} cell_t;

	////////////////////
	// Drawing request and tile data
	////////////////////

	typedef struct packed {
		logic [9:0] addr;
		logic [1:0] z;
		logic [3:0] palette;
		logic [3:0] first;
		logic [3:0] last;
	} sprite_t;

	// Pixel 0 sits in the low nibble
	typedef struct packed {
		logic [7:0][3:0] data;
		logic flip;
	} tile_t;

	// Pixels pushed past the end of a word, waiting for the next word
	typedef struct packed {
		logic [2:0][3:0] color;
		logic [1:0] count;
	} carry_t;

endpackage

/* source/line_ram.sv */
`timescale 1ns/1ps

module line_ram (
	input  logic clk,

	// Drawing port, read then write of the same word
	input  logic bank_a,
	input  logic [7:0] addr_a,
	input  logic en_a,
	input  logic we_a,
	input  line_pkg::cell_t wdata_a,
	output line_pkg::cell_t rdata_a,

	// Scan-out port
	input  logic bank_b,
	input  logic [7:0] addr_b,
	output line_pkg::cell_t rdata_b
);
	import line_pkg::*;

	cell_t mem [0:1][0:line_words-1];

	////////////////////
	// Port A
	////////////////////

	// Read-first, the read data of a write cycle is the old word
	always_ff @(posedge clk) begin
		if (en_a) begin
			if (we_a) begin
				mem[bank_a][addr_a] <= wdata_a;
			end
			rdata_a <= mem[bank_a][addr_a];
		end
	end

	////////////////////
	// Port B
	////////////////////

	always_ff @(posedge clk) begin
		rdata_b <= mem[bank_b][addr_b];
	end

endmodule

/* source/pixel_merge.sv */
`timescale 1ns/1ps

module pixel_merge (
	input  line_pkg::tile_t tile,
	input  logic flip_half,
	input  logic [1:0] offset,
	input  line_pkg::sprite_t sprite,
	input  line_pkg::carry_t carry_in,
	input  line_pkg::cell_t cell_in,
	output line_pkg::cell_t cell_out,
	output line_pkg::carry_t carry_out
);
	import line_pkg::*;

	logic [tile_pix-1:0][3:0] ordered;
	logic [word_pix-1:0][3:0] half_pix;
	logic [word_pix-1:0][3:0] lane_color;
	logic live;

	// An empty tile range marks the trailing word, only carried pixels are left
	assign live = sprite.first <= sprite.last;

	////////////////////
	// Mirror and half select
	////////////////////

	always_comb begin
		for (int i = 0; i < tile_pix; i++) begin
			if (tile.flip) begin
				ordered[i] = tile.data[tile_pix-1-i];
			end else begin
				ordered[i] = tile.data[i];
			end
		end
	end

	always_comb begin
		for (int j = 0; j < word_pix; j++) begin
			half_pix[j] = live ? ordered[flip_half*word_pix+j] : 4'h0;
		end
	end

	////////////////////
	// Shift by offset
	////////////////////

	// Low lanes come from the previous word's overflow
	always_comb begin
		for (int l = 0; l < word_pix; l++) begin
			if (l < offset) begin
				lane_color[l] = (l < carry_in.count) ? carry_in.color[l] : 4'h0;
			end else begin
				lane_color[l] = half_pix[l-offset];
			end
		end
	end

	always_comb begin
		carry_out.count = offset;
		for (int k = 0; k < 3; k++) begin
			if (k < offset) begin
				carry_out.color[k] = half_pix[word_pix-offset+k];
			end else begin
				carry_out.color[k] = 4'h0;
			end
		end
	end

	////////////////////
	// Priority merge
	////////////////////

	// Equal priority lets the later sprite win
	always_comb begin
		cell_out = cell_in;
		for (int l = 0; l < word_pix; l++) begin
			if (lane_color[l] != 4'h0 && (!cell_in.written[l] || sprite.z >= cell_in.z[l])) begin
				cell_out.pix[l].palette = sprite.palette;
				cell_out.pix[l].color = lane_color[l];
				cell_out.z[l] = sprite.z;
				cell_out.written[l] = 1'b1;
			end
		end
	end

endmodule

/* source/line_sequencer.sv */
`timescale 1ns/1ps

module line_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic bank_sel,

	// Request side
	input  logic load,
	input  line_pkg::sprite_t sprite,
	output logic line_busy,

	// Tile walk and merge control
	output logic [3:0] tile_index,
	output logic half,
	output logic [1:0] offset,
	output line_pkg::sprite_t sprite_q,
	output line_pkg::carry_t carry_q,
	input  line_pkg::carry_t carry_next,

	// Memory port A control
	output logic mem_bank,
	output logic [7:0] mem_addr,
	output logic mem_en,
	output logic mem_we,
	output logic clearing
);
	import line_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_read,
		st_write,
		st_clear
	} state_t;

	state_t state;

	// Nine bits so a strip running off the right end never wraps to word 0
	logic [8:0] word;
	logic draw_bank;
	logic init;
	logic swap;
	logic accept;
	logic no_tiles;
	logic in_range;
	logic last_tile;

	assign swap = init || (bank_sel != draw_bank);
	assign accept = (state == st_idle) && !swap && load;
	assign no_tiles = sprite_q.first > sprite_q.last;
	assign in_range = word < 9'(line_words);
	assign last_tile = tile_index == sprite_q.last;

	////////////////////
	// Outputs
	////////////////////

	assign line_busy = state != st_idle;
	assign offset = sprite_q.addr[1:0];
	assign mem_bank = draw_bank;
	assign mem_addr = word[7:0];
	assign clearing = state == st_clear;

	// Words past pixel 639 are neither read nor written
	assign mem_en = clearing || ((state == st_read || state == st_write) && in_range);
	assign mem_we = clearing || (state == st_write && in_range);

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
			draw_bank <= 1'b0;
			init <= 1'b1;
			word <= '0;
			tile_index <= '0;
			half <= 1'b0;
			carry_q <= '0;
		end else begin
			case (state)
				st_idle: begin
					// Bank swap first, a strip in progress is never split
					if (swap) begin
						draw_bank <= bank_sel;
						init <= 1'b0;
						word <= '0;
						state <= st_clear;
					end else if (load) begin
						tile_index <= sprite.first;
						half <= 1'b0;
						word <= {1'b0, sprite.addr[9:2]};
						carry_q <= '0;
						state <= st_start;
					end
				end
				st_start: begin
					state <= no_tiles ? st_idle : st_read;
				end
				st_read: begin
					state <= st_write;
				end
				st_write: begin
					word <= word + 9'd1;
					carry_q <= carry_next;
					if (no_tiles) begin
						state <= st_idle;
					end else if (!half) begin
						half <= 1'b1;
						state <= st_read;
					end else begin
						half <= 1'b0;
						if (!last_tile) begin
							tile_index <= tile_index + 4'd1;
							state <= st_read;
						end else if (offset != 2'd0) begin
							// One more word for the pixels still carried
							state <= st_read;
						end else begin
							state <= st_idle;
						end
					end
				end
				st_clear: begin
					word <= word + 9'd1;
					if (word == 9'(line_words - 1)) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	////////////////////
	// Request register
	////////////////////

	// After the last tile the range is emptied so the merger sees no tile
	always_ff @(posedge clk) begin
		if (accept) begin
			sprite_q <= sprite;
		end else if (state == st_write && half && last_tile) begin
			sprite_q.first <= 4'hf;
			sprite_q.last <= 4'h0;
		end
	end

endmodule

/* source/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
	input  logic clk,
	input  logic rst,
	input  logic bank_sel,

	// Sprite request
	input  logic load,
	input  line_pkg::sprite_t sprite,
	output logic line_busy,

	// Tile memory, answered in the same cycle
	output logic [3:0] tile_index,
	input  line_pkg::tile_t tile,

	// Scan-out to the palette stage
	input  logic [9:0] x,
	output line_pkg::pix_t index,
	output logic enable
);
	import line_pkg::*;

	logic half;
	logic [1:0] offset;
	sprite_t sprite_q;
	carry_t carry_q;
	carry_t carry_next;
	logic mem_bank;
	logic [7:0] mem_addr;
	logic mem_en;
	logic mem_we;
	logic clearing;
	cell_t rdata_a;
	cell_t merged;
	cell_t wdata_a;
	cell_t rdata_b;
	logic [1:0] x_lane;

	////////////////////
	// Drawing path
	////////////////////

	line_sequencer u_seq (
		.clk        (clk),
		.rst        (rst),
		.bank_sel   (bank_sel),
		.load       (load),
		.sprite     (sprite),
		.line_busy  (line_busy),
		.tile_index (tile_index),
		.half       (half),
		.offset     (offset),
		.sprite_q   (sprite_q),
		.carry_q    (carry_q),
		.carry_next (carry_next),
		.mem_bank   (mem_bank),
		.mem_addr   (mem_addr),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.clearing   (clearing)
	);

	pixel_merge u_merge (
		.tile      (tile),
		.flip_half (half),
		.offset    (offset),
		.sprite    (sprite_q),
		.carry_in  (carry_q),
		.cell_in   (rdata_a),
		.cell_out  (merged),
		.carry_out (carry_next)
	);

	// Clear sweep writes empty words with all flags low
	assign wdata_a = clearing ? '0 : merged;

	line_ram u_ram (
		.clk     (clk),
		.bank_a  (mem_bank),
		.addr_a  (mem_addr),
		.en_a    (mem_en),
		.we_a    (mem_we),
		.wdata_a (wdata_a),
		.rdata_a (rdata_a),
		.bank_b  (~bank_sel),
		.addr_b  (x[9:2]),
		.rdata_b (rdata_b)
	);

	////////////////////
	// Scan-out select
	////////////////////

	// Lane follows the word read by one cycle
	always_ff @(posedge clk) begin
		x_lane <= x[1:0];
	end

	assign index = rdata_b.pix[x_lane];
	assign enable = rdata_b.written[x_lane];

endmodule

/* bench/line_buffer_chk.sv */
`timescale 1ns/1ps

module line_buffer_chk (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic line_busy,
	input  logic mem_we,
	input  logic [7:0] mem_addr
);
	import line_pkg::*;

	// Number of failed assertions
	int fail_count = 0;

	// Sequencer comes out of reset idle
	a_reset_idle: assert property (@(posedge clk) !rst |=> !line_busy)
	else begin
		$error("line_busy is high in the cycle after reset");
		fail_count++;
	end

	// A load seen while idle always starts a strip or a pending clear
	a_load_busy: assert property (@(posedge clk) disable iff (!rst)
		load && !line_busy |=> line_busy)
	else begin
		$error("line_busy stayed low after a load was accepted");
		fail_count++;
	end

	// Words past pixel 639 are never written
	a_clip: assert property (@(posedge clk) disable iff (!rst)
		mem_we |-> mem_addr < 8'(line_words))
	else begin
		$error("write to word %0d, past the end of the line", mem_addr);
		fail_count++;
	end

endmodule

/* bench/line_buffer_mon.sv */
`timescale 1ns/1ps

module line_buffer_mon (
	input  logic clk,
	input  logic bank_sel,
	input  logic [9:0] x,
	input  line_pkg::pix_t index,
	input  logic enable,
	input  logic scan_on
);
	import line_pkg::*;

	// Reference copy of both banks, one entry per pixel
	pix_t model_pix [0:1][0:line_w-1];
	logic [1:0] model_z [0:1][0:line_w-1];
	logic model_wr [0:1][0:line_w-1];

	int error_count = 0;
	int check_count = 0;
	int failed_tests = 0;
	int test_errors = 0;
	int test_checks = 0;

	logic [9:0] x_q;
	logic bank_q;
	logic scan_q;

	////////////////////
	// Model updates
	////////////////////

	task automatic clear_bank(input logic b);
		for (int p = 0; p < line_w; p++) begin
			model_pix[b][p] = '0;
			model_z[b][p] = '0;
			model_wr[b][p] = 1'b0;
		end
	endtask

	// The strip is a run of pixels, one per address from addr upward
	task automatic draw_strip(input logic b, input sprite_t s, input tile_t [15:0] set);
		tile_t t;
		logic [3:0] c;
		int a;
		a = s.addr;
		for (int n = s.first; n <= s.last; n++) begin
			t = set[n];
			for (int i = 0; i < tile_pix; i++) begin
				c = t.flip ? t.data[tile_pix-1-i] : t.data[i];
				if (a < line_w && c != 4'h0 && (!model_wr[b][a] || s.z >= model_z[b][a])) begin
					model_pix[b][a] = {s.palette, c};
					model_z[b][a] = s.z;
					model_wr[b][a] = 1'b1;
				end
				a++;
			end
		end
	endtask

	initial begin
		clear_bank(1'b0);
		clear_bank(1'b1);
	end

	////////////////////
	// Scan-out compare
	////////////////////

	always_ff @(posedge clk) begin
		x_q <= x;
		bank_q <= ~bank_sel;
		scan_q <= scan_on;
	end

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		error_count++;
		test_errors++;
		$display("Fail at %0d ns: %s expected %h, got %h (x=%0d)", $time, name, expected,
			actual, x_q);
	endtask

	// Outputs hold the word read at the last rising edge
	always @(negedge clk) begin
		if (scan_q === 1'b1) begin
			check_count++;
			test_checks++;
			if (enable !== model_wr[bank_q][x_q]) begin
				report_mismatch("enable", 8'(model_wr[bank_q][x_q]), 8'(enable));
			end
			if (index !== model_pix[bank_q][x_q]) begin
				report_mismatch("index", model_pix[bank_q][x_q], index);
			end
		end
	end

	task automatic finish_test(input int n, input string name);
		if (test_checks != line_w) begin
			$display("Test %0d scanned %0d pixels instead of %0d", n, test_checks, line_w);
		end
		if (test_errors != 0 || test_checks != line_w) begin
			failed_tests++;
		end
		$display("Test %0d (%s): %0d pixels checked, %0d mismatches, %s", n, name,
			test_checks, test_errors, (test_errors == 0) ? "ok" : "bad");
		test_errors = 0;
		test_checks = 0;
	endtask

endmodule

/* bench/line_buffer_tb.sv */
`timescale 1ns/1ps

module line_buffer_tb;
	import line_pkg::*;

	localparam int num_tests = 11;
	localparam int cycle_ns = 100;

	typedef struct packed {
		logic bank;
		logic [1:0] set;
		logic [2:0] count;
		sprite_t [3:0] spr;
	} test_t;

	logic clk;
	logic rst;
	logic bank_sel;
	logic load;
	sprite_t sprite;
	logic line_busy;
	logic [3:0] tile_index;
	tile_t tile;
	logic [9:0] x;
	pix_t index;
	logic enable;
	logic scan_on;
	logic [1:0] cur_set;

	tile_t [15:0] tile_sets [0:3];
	test_t tests [0:num_tests-1];

	line_buffer u_dut (.*);

	line_buffer_mon u_mon (.*);

	bind line_buffer line_buffer_chk u_chk (.*);

	// Tile memory answers in the same cycle
	assign tile = tile_sets[cur_set][tile_index];

	initial begin
		clk = 1'b0;
		forever #(cycle_ns / 2) clk = ~clk;
	end

	initial begin
		#(num_tests * 2500 * cycle_ns);
		$display("Timeout: the run went past %0d cycles before all tests ended",
			num_tests * 2500);
		$display("test failed");
		$finish;
	end

	////////////////////
	// Stimulus table
	////////////////////

	function automatic sprite_t make_sprite(input int addr, input int z, input int pal,
		input int first, input int last);
		sprite_t s;
		s.addr = 10'(addr);
		s.z = 2'(z);
		s.palette = 4'(pal);
		s.first = 4'(first);
		s.last = 4'(last);
		return s;
	endfunction

	function automatic sprite_t random_sprite();
		int first;
		int last;
		first = $urandom % 16;
		last = first + $urandom % 3;
		if ($urandom % 5 == 0) begin
			last = $urandom % 16;
		end
		if (last > 15) begin
			last = 15;
		end
		return make_sprite($urandom % 660, $urandom % 4, $urandom % 16, first, last);
	endfunction

	function automatic test_t make_test(input logic bank, input int set, input int count,
		input sprite_t s0, input sprite_t s1, input sprite_t s2, input sprite_t s3);
		test_t t;
		t.bank = bank;
		t.set = 2'(set);
		t.count = 3'(count);
		t.spr = {s3, s2, s1, s0};
		return t;
	endfunction

	// Colors mix set, tile and pixel so zeros land in scattered places
	function automatic tile_t pattern_tile(input int set, input int idx);
		tile_t t;
		for (int i = 0; i < tile_pix; i++) begin
			t.data[i] = 4'((set * 11 + idx * 5 + i * 3 + idx * i) % 16);
		end
		t.flip = (set == 1) ? idx[0] : ((set == 2) ? idx[1] : 1'b0);
		return t;
	endfunction

	function automatic string test_name(input int n);
		case (n)
			0: return "aligned strip";
			1: return "unaligned and mirrored";
			2: return "priority";
			3: return "clipping";
			4: return "bank clearing";
			default: return "random strips";
		endcase
	endfunction

	task automatic build_tests;
		tests[0] = make_test(0, 0, 1, make_sprite(64, 1, 3, 2, 2), '0, '0, '0);
		tests[1] = make_test(1, 1, 4, make_sprite(101, 1, 5, 0, 2),
			make_sprite(202, 2, 6, 3, 4), make_sprite(303, 0, 7, 5, 7),
			make_sprite(400, 3, 8, 8, 9));
		tests[2] = make_test(0, 2, 4, make_sprite(200, 1, 1, 0, 3),
			make_sprite(210, 2, 2, 4, 5), make_sprite(205, 0, 3, 6, 7),
			make_sprite(220, 2, 4, 8, 9));
		tests[3] = make_test(1, 1, 4, make_sprite(620, 2, 9, 0, 5),
			make_sprite(637, 3, 10, 2, 3), make_sprite(100, 3, 11, 5, 3),
			make_sprite(10, 3, 12, 1, 1));
		tests[4] = make_test(1, 0, 1, make_sprite(300, 1, 13, 4, 5), '0, '0, '0);
		for (int n = 5; n < num_tests; n++) begin
			tests[n] = make_test(1'($urandom % 2), 3, 1 + $urandom % 4, random_sprite(),
				random_sprite(), random_sprite(), random_sprite());
		end
	endtask

	////////////////////
	// Drive tasks
	////////////////////

	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	// At least one edge passes so a bank change is seen first
	task automatic wait_idle;
		next_cycle();
		while (line_busy) begin
			next_cycle();
		end
	endtask

	task automatic select_bank(input logic b);
		if (bank_sel !== b) begin
			bank_sel = b;
			u_mon.clear_bank(b);
		end
		wait_idle();
	endtask

	task automatic load_sprite(input sprite_t s);
		sprite = s;
		load = 1'b1;
		next_cycle();
		load = 1'b0;
		while (line_busy) begin
			next_cycle();
		end
	endtask

	task automatic scan_line;
		scan_on = 1'b1;
		for (int i = 0; i < line_w; i++) begin
			x = 10'(i);
			next_cycle();
		end
		scan_on = 1'b0;
		next_cycle();
	endtask

	task automatic run_test(input int n);
		test_t t;
		t = tests[n];
		cur_set = t.set;
		select_bank(t.bank);
		for (int k = 0; k < t.count; k++) begin
			u_mon.draw_strip(t.bank, t.spr[k], tile_sets[t.set]);
			load_sprite(t.spr[k]);
		end
		select_bank(!t.bank);
		scan_line();
		u_mon.finish_test(n, test_name(n));
	endtask

	initial begin
		rst = 1'b0;
		bank_sel = 1'b0;
		load = 1'b0;
		sprite = '0;
		x = '0;
		scan_on = 1'b0;
		cur_set = '0;
		void'($urandom(32'hf479));
		for (int s = 0; s < 3; s++) begin
			for (int j = 0; j < 16; j++) begin
				tile_sets[s][j] = pattern_tile(s, j);
			end
		end
		for (int j = 0; j < 16; j++) begin
			tile_sets[3][j].data = $urandom;
			tile_sets[3][j].flip = 1'($urandom % 2);
		end
		build_tests();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		for (int n = 0; n < num_tests; n++) begin
			run_test(n);
		end
		$display("Summary: %0d of %0d tests clean, %0d pixels checked, %0d mismatches, %0d %s",
			num_tests - u_mon.failed_tests, num_tests, u_mon.check_count, u_mon.error_count,
			u_dut.u_chk.fail_count, "assertion failures");
		if (u_mon.error_count == 0 && u_mon.failed_tests == 0
			&& u_mon.check_count == num_tests * line_w
			&& u_dut.u_chk.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* src.f */
source/line_pkg.sv
source/line_ram.sv
source/pixel_merge.sv
source/line_sequencer.sv
source/line_buffer.sv
bench/line_buffer_chk.sv
bench/line_buffer_mon.sv
bench/line_buffer_tb.sv

/* Bender.yml */
package:
  name: line_buffer

sources:
  - source/line_pkg.sv
  - source/line_ram.sv
  - source/pixel_merge.sv
  - source/line_sequencer.sv
  - source/line_buffer.sv
  - target: simulation
    files:
      - bench/line_buffer_chk.sv
      - bench/line_buffer_mon.sv
      - bench/line_buffer_tb.sv
